// ==== common/uno_pkg.sv ====
package uno_pkg;

    localparam int NUM_SEATS    = 4;
    localparam int CARD_W       = 6;
    localparam int PEN_W        = 3;    // holds a penalty of up to 4
    localparam int PENALTY_TWO  = 2;
    localparam int PENALTY_FOUR = 4;

    typedef enum logic [1:0] {
        col_red    = 2'd0,
        col_yellow = 2'd1,
        col_green  = 2'd2,
        col_blue   = 2'd3
    } card_color_e;

    typedef enum logic [3:0] {
        val_n0        = 4'd0,
        val_n1        = 4'd1,
        val_n2        = 4'd2,
        val_n3        = 4'd3,
        val_n4        = 4'd4,
        val_n5        = 4'd5,
        val_n6        = 4'd6,
        val_n7        = 4'd7,
        val_n8        = 4'd8,
        val_n9        = 4'd9,
        val_skip      = 4'd10,
        val_reverse   = 4'd11,
        val_draw_two  = 4'd12,
        val_wild      = 4'd13,
        val_wild_four = 4'd14,
        val_none      = 4'd15    // not a card
    } card_value_e;

    // color sits in the upper two bits, value in [3:0]
    typedef struct packed {
        card_color_e color;    // chosen color on wild cards
        card_value_e value;
    } card_t;

    typedef enum logic [1:0] {
        seat_player = 2'd0,
        seat_com0   = 2'd1,
        seat_com1   = 2'd2,
        seat_com2   = 2'd3
    } seat_e;

    typedef enum logic [1:0] {
        act_pass    = 2'd0,
        act_skip    = 2'd1,
        act_reverse = 2'd2,
        act_draw    = 2'd3
    } action_e;

    typedef struct packed {
        logic             legal;
        action_e          act;
        logic [PEN_W-1:0] penalty;
    } action_t;

    typedef struct packed {
        seat_e          seat;
        logic           reversed;
        logic [PEN_W:0] penalty;    // owed by the current seat
    } turn_t;

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_eval    = 2'd1,
        st_ack     = 2'd2,
        st_release = 2'd3
    } pile_state_e;

    localparam turn_t TURN_START = '{seat: seat_player, reversed: 1'b0, penalty: '0};

endpackage

// ==== src/play_decode.sv ====
`timescale 1ns/1ps

module play_decode (
    input  logic             i_clk,
    input  uno_pkg::card_t   i_card,
    input  uno_pkg::card_t   i_top,
    output uno_pkg::action_t o_action
);
    import uno_pkg::*;

    logic    is_wild;
    logic    color_match;
    logic    value_match;
    action_t action_w;

    assign is_wild     = (i_card.value == val_wild) || (i_card.value == val_wild_four);
    assign color_match = (i_card.color == i_top.color);
    assign value_match = (i_card.value == i_top.value);

    always_comb begin
        action_w.legal   = (i_card.value != val_none) && (is_wild || color_match || value_match);
        action_w.act     = act_pass;
        action_w.penalty = '0;
        case (i_card.value)
            val_skip: begin
                action_w.act = act_skip;
            end
            val_reverse: begin
                action_w.act = act_reverse;
            end
            val_draw_two: begin
                action_w.act     = act_draw;
                action_w.penalty = PEN_W'(PENALTY_TWO);
            end
            val_wild_four: begin
                action_w.act     = act_draw;
                action_w.penalty = PEN_W'(PENALTY_FOUR);
            end
            default: begin
                action_w.act = act_pass;    // numbers and plain wild
            end
        endcase
    end

    assign o_action = action_w;

    // only the two draw cards carry a penalty
    penalty_values: assert property (
        @(posedge i_clk)
        o_action.penalty inside {'0, PEN_W'(PENALTY_TWO), PEN_W'(PENALTY_FOUR)}
    ) else $error("play_decode: penalty %0d out of range", o_action.penalty);

endmodule

// ==== src/turn_execute.sv ====
`timescale 1ns/1ps

module turn_execute (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  logic             i_commit,
    input  uno_pkg::action_t i_action,
    output uno_pkg::turn_t   o_turn
);
    import uno_pkg::*;

    turn_t turn_w, turn_r;
    logic  rev_nxt;

    // move a number of seats around the table in the given direction
    function automatic seat_e step_seat(seat_e seat, logic rev, int hops);
        int idx;
        if (rev) begin
            idx = int'(seat) + NUM_SEATS - hops;
        end else begin
            idx = int'(seat) + hops;
        end
        return seat_e'(2'(idx % NUM_SEATS));
    endfunction

    assign rev_nxt = turn_r.reversed ^ (i_action.act == act_reverse);

    always_comb begin
        turn_w = turn_r;
        if (i_start) begin
            turn_w = TURN_START;
        end else if (i_commit) begin
            turn_w.reversed = rev_nxt;
            turn_w.penalty  = '0;    // cleared unless a draw card
            case (i_action.act)
                act_skip: begin
                    turn_w.seat = step_seat(turn_r.seat, turn_r.reversed, 2);
                end
                act_reverse: begin
                    turn_w.seat = step_seat(turn_r.seat, rev_nxt, 1);    // new direction
                end
                act_draw: begin
                    turn_w.seat    = step_seat(turn_r.seat, turn_r.reversed, 1);
                    turn_w.penalty = {1'b0, i_action.penalty};
                end
                default: begin
                    turn_w.seat = step_seat(turn_r.seat, turn_r.reversed, 1);
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            turn_r <= TURN_START;
        end else begin
            turn_r <= turn_w;
        end
    end

    assign o_turn = turn_r;

    // the pile must only commit cards the decoder called legal
    commit_is_legal: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_commit |-> i_action.legal
    ) else $error("turn_execute: commit on an illegal card");

endmodule

// ==== src/discard_pile.sv ====
`timescale 1ns/1ps

module discard_pile (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_start,
    input  uno_pkg::card_t   i_first_card,
    input  logic             i_play_req,
    input  uno_pkg::card_t   i_play_card,
    input  uno_pkg::action_t i_action,
    output uno_pkg::card_t   o_card,
    output uno_pkg::card_t   o_top_card,
    output logic             o_commit,
    output logic             o_play_ack,
    output logic             o_accepted
);
    import uno_pkg::*;

    pile_state_e state_w, state_r;
    card_t       card_w, card_r;
    card_t       top_w, top_r;
    logic        acc_w, acc_r;

    always_comb begin
        state_w = state_r;
        card_w  = card_r;
        top_w   = top_r;
        acc_w   = acc_r;
        if (i_start) begin
            top_w = i_first_card;    // new game
        end
        case (state_r)
            st_idle: begin
                if (i_play_req) begin
                    state_w = st_eval;
                    card_w  = i_play_card;
                end
            end
            st_eval: begin
                state_w = st_ack;
                acc_w   = i_action.legal;
                if (i_action.legal) begin
                    top_w = card_r;
                end
            end
            st_ack: begin
                if (!i_play_req) begin
                    state_w = st_release;
                end
            end
            default: begin    // st_release, ack drops next edge
                state_w = st_idle;
                acc_w   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_r <= st_idle;
            top_r   <= card_t'({CARD_W{1'b0}});
            acc_r   <= 1'b0;
        end else begin
            state_r <= state_w;
            top_r   <= top_w;
            acc_r   <= acc_w;
        end
    end

    always_ff @(posedge i_clk) begin
        card_r <= card_w;
    end

    assign o_card     = card_r;
    assign o_top_card = top_r;
    assign o_commit   = (state_r == st_eval) && i_action.legal;
    assign o_play_ack = (state_r == st_ack) || (state_r == st_release);
    assign o_accepted = acc_r;

    ack_after_req: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_play_ack) |-> $past(i_play_req)
    ) else $error("discard_pile: ack rose without a pending request");

    commit_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_commit |=> !o_commit
    ) else $error("discard_pile: commit held longer than one cycle");

endmodule

// ==== src/uno_table.sv ====
`timescale 1ns/1ps

module uno_table (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_start,
    input  uno_pkg::card_t i_first_card,
    input  logic           i_play_req,
    input  uno_pkg::card_t i_play_card,
    output logic           o_play_ack,
    output logic           o_accepted,
    output uno_pkg::card_t o_top_card,
    output uno_pkg::turn_t o_turn
);
    import uno_pkg::*;

    card_t   latched_card;    // card under evaluation
    action_t action;
    logic    commit;

    play_decode u_play_decode (
        .i_clk    (i_clk),
        .i_card   (latched_card),
        .i_top    (o_top_card),
        .o_action (action)
    );

    turn_execute u_turn_execute (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_commit (commit),
        .i_action (action),
        .o_turn   (o_turn)
    );

    discard_pile u_discard_pile (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_first_card (i_first_card),
        .i_play_req   (i_play_req),
        .i_play_card  (i_play_card),
        .i_action     (action),
        .o_card       (latched_card),
        .o_top_card   (o_top_card),
        .o_commit     (commit),
        .o_play_ack   (o_play_ack),
        .o_accepted   (o_accepted)
    );

endmodule

// ==== tests/tb_uno_table.sv ====
`timescale 1ns/1ps

module tb_uno_table;
    import uno_pkg::*;

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 10;
    localparam int    HS_TIMEOUT   = 20;    // cycles per handshake phase
    localparam int    WATCH_CYCLES = 20;    // budget per file line
    localparam int    SEED         = 32'ha43f_37b9;
    localparam string TEST_FILE    = "tests/uno_tests.txt";

    logic  clk;
    logic  rst_n;
    logic  start;
    card_t first_card;
    logic  play_req;
    card_t play_card;
    logic  play_ack;
    logic  accepted;
    card_t top_card;
    turn_t turn;

    // one entry per test line
    byte        op_q[$];
    logic [5:0] card_q[$];
    logic       acc_q[$];
    logic [1:0] seat_q[$];
    logic       rev_q[$];
    logic [3:0] pen_q[$];
    logic [5:0] top_q[$];

    int n_lines;
    int n_pass;
    int n_fail;
    int test_err;
    bit loaded;

    uno_table i_uno_table (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_start      (start),
        .i_first_card (first_card),
        .i_play_req   (play_req),
        .i_play_card  (play_card),
        .o_play_ack   (play_ack),
        .o_accepted   (accepted),
        .o_top_card   (top_card),
        .o_turn       (turn)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_tests();
        int    fd;
        int    n;
        string line;
        byte   op;
        int    f_card;
        int    f_acc;
        int    f_seat;
        int    f_rev;
        int    f_pen;
        int    f_top;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("cannot open test file %s", TEST_FILE);
            n_fail++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n_lines++;
                if (line.len() < 2 || line[0] == "#") begin
                    continue;    // comment or blank
                end
                n = $sscanf(line, "%c %h %h %h %h %h %h",
                            op, f_card, f_acc, f_seat, f_rev, f_pen, f_top);
                if (n != 7 || !(op == "S" || op == "P")) begin
                    $display("unreadable line %0d in %s", n_lines, TEST_FILE);
                    n_fail++;
                    continue;
                end
                op_q.push_back(op);
                card_q.push_back(f_card[5:0]);
                acc_q.push_back(f_acc[0]);
                seat_q.push_back(f_seat[1:0]);
                rev_q.push_back(f_rev[0]);
                pen_q.push_back(f_pen[3:0]);
                top_q.push_back(f_top[5:0]);
            end
            $fclose(fd);
        end
    endtask

    // inputs change a little after the rising edge
    task automatic after_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) after_edge();
        rst_n = 1'b1;
    endtask

    task automatic check_outputs(input int idx);
        assert (accepted == acc_q[idx]) else begin
            $display("FAILED at %0t ns: test %0d accepted %0b, expected %0b",
                     $time, idx + 1, accepted, acc_q[idx]);
            test_err++;
        end
        assert (turn.seat == seat_q[idx]) else begin
            $display("FAILED at %0t ns: test %0d seat %0d, expected %0d",
                     $time, idx + 1, turn.seat, seat_q[idx]);
            test_err++;
        end
        assert (turn.reversed == rev_q[idx]) else begin
            $display("FAILED at %0t ns: test %0d reversed %0b, expected %0b",
                     $time, idx + 1, turn.reversed, rev_q[idx]);
            test_err++;
        end
        assert (turn.penalty == pen_q[idx]) else begin
            $display("FAILED at %0t ns: test %0d penalty %0d, expected %0d",
                     $time, idx + 1, turn.penalty, pen_q[idx]);
            test_err++;
        end
        assert (top_card == top_q[idx]) else begin
            $display("FAILED at %0t ns: test %0d top card %h, expected %h",
                     $time, idx + 1, top_card, top_q[idx]);
            test_err++;
        end
    endtask

    task automatic run_start(input int idx);
        start      = 1'b1;
        first_card = card_t'(card_q[idx]);
        after_edge();
        start = 1'b0;
        after_edge();
        check_outputs(idx);
    endtask

    task automatic run_play(input int idx);
        int waited;
        bit got_ack;
        repeat ($urandom_range(3, 0)) after_edge();
        play_req  = 1'b1;
        play_card = card_t'(card_q[idx]);
        waited    = 0;
        got_ack   = 1'b0;
        while (!got_ack && waited < HS_TIMEOUT) begin
            after_edge();
            waited++;
            got_ack = play_ack;
        end
        if (!got_ack) begin
            $display("test %0d: ack never rose within %0d cycles", idx + 1, HS_TIMEOUT);
            test_err++;
        end else begin
            check_outputs(idx);
            repeat ($urandom_range(3, 0)) after_edge();    // hold req a while
        end
        play_req = 1'b0;
        waited   = 0;
        while (play_ack && waited < HS_TIMEOUT) begin
            after_edge();
            waited++;
        end
        if (play_ack) begin
            $display("test %0d: ack never fell within %0d cycles", idx + 1, HS_TIMEOUT);
            test_err++;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        first_card = '0;
        play_req   = 1'b0;
        play_card  = '0;
        n_lines    = 0;
        n_pass     = 0;
        n_fail     = 0;
        loaded     = 1'b0;
        load_tests();
        loaded = 1'b1;
        apply_reset();
        for (int idx = 0; idx < op_q.size(); idx++) begin
            test_err = 0;
            if (op_q[idx] == "S") begin
                run_start(idx);
            end else begin
                run_play(idx);
            end
            if (test_err == 0) begin
                n_pass++;
                $display("test %0d %c %h: ok", idx + 1, op_q[idx], card_q[idx]);
            end else begin
                n_fail++;
                $display("test %0d %c %h: failed", idx + 1, op_q[idx], card_q[idx]);
            end
        end
        $display("tests %0d, passed %0d, failed %0d", op_q.size(), n_pass, n_fail);
        if (n_fail == 0 && n_pass > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // ends a run that stalls
    initial begin
        wait (loaded);
        #(n_lines * WATCH_CYCLES * CLK_PERIOD);
        $display("watchdog: run still going after %0d cycles", n_lines * WATCH_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/uno_tests.txt ====
# op card accepted seat reversed penalty top, all hex
# card = color<<4 | value, color 0 red 1 yellow 2 green 3 blue
S 05 0 0 0 0 05
P 07 1 1 0 0 07
P 17 1 2 0 0 17
P 2d 1 3 0 0 2d
P 23 1 0 0 0 23
P 15 0 0 0 0 23
P 2f 0 0 0 0 23
P 2a 1 2 0 0 2a
P 2b 1 1 1 0 2b
P 3b 1 2 0 0 3b
P 3b 1 1 1 0 3b
P 3a 1 3 1 0 3a
P 1a 1 1 1 0 1a
P 1c 1 0 1 2 1c
P 0c 1 3 1 2 0c
P 04 1 2 1 0 04
P 1e 1 1 1 4 1e
P 26 0 1 1 4 1e
P 16 1 0 1 0 16
P 1b 1 1 0 0 1b
S 32 0 0 0 0 32
P 39 1 1 0 0 39
P 3e 1 2 0 4 3e
P 0d 1 3 0 0 0d
P 0a 1 1 0 0 0a
P 2a 1 3 0 0 2a
P 2c 1 0 0 2 2c
P 2b 1 3 1 0 2b
P 3d 1 2 1 0 3d
P 1d 1 1 1 0 1d
P 0e 1 0 1 4 0e
P 3f 0 0 1 4 0e
P 0b 1 1 0 0 0b
P 0b 1 0 1 0 0b

// ==== uno_table.f ====
common/uno_pkg.sv
src/play_decode.sv
src/turn_execute.sv
src/discard_pile.sv
src/uno_table.sv
tests/tb_uno_table.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_uno_table
FLIST     := uno_table.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
